//--- common/cpu_pkg.sv
`ifndef CPU_PKG_SV
`define CPU_PKG_SV

package cpu_pkg;

    // byte address on the RAM bus
    typedef logic [23:0] addr_t;
    typedef logic [15:0] word_t;
    typedef logic [ 2:0] reg_sel_t;
    typedef logic [ 3:0] op_t;

    // opcode field, instruction bits 15:12
    localparam op_t op_nop  = 4'h0;
    localparam op_t op_ldi  = 4'h1;
    localparam op_t op_add  = 4'h2;
    localparam op_t op_sub  = 4'h3;
    localparam op_t op_ldx  = 4'h4;
    localparam op_t op_stx  = 4'h5;
    localparam op_t op_ldxp = 4'h6;
    localparam op_t op_stxp = 4'h7;
    localparam op_t op_stbx = 4'h8;
    localparam op_t op_jp   = 4'h9;
    localparam op_t op_halt = 4'hf;

    typedef enum logic [3:0] {
        st_reset,
        st_fetch,
        st_fetch_wait,
        st_fetch_imm,
        st_decode,
        st_exec,
        st_mem,
        st_wb,
        st_halted
    } ctrl_state_e;

    typedef enum logic [1:0] {
        ram_idle,
        ram_read,
        ram_write
    } ram_state_e;

endpackage

`endif

//--- regs/cpu_regs.sv
`timescale 1ns/1ns

module cpu_regs import cpu_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     cen,

    input  reg_sel_t src,
    input  reg_sel_t dst,
    input  logic     we,
    input  word_t    wr_data,

    // post-increment from the index unit
    input  reg_sel_t idx_rdreg_sel,
    input  logic     reg_inc,
    input  logic [1:0] reg_step,

    output word_t    src_out,
    output word_t    dst_out,

    input  logic [7:0] dmp_addr,
    output logic [7:0] dmp_din
);

    word_t regs [8];
    word_t dmp_word;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (cen) begin
            if (reg_inc) begin
                regs[idx_rdreg_sel] <= regs[idx_rdreg_sel] + {14'd0, reg_step};
            end
            if (we) begin
                regs[dst] <= wr_data;
            end
        end
    end

    assign src_out = regs[src];
    assign dst_out = regs[dst];

    // dump port, byte 0 is the low byte
    assign dmp_word = regs[dmp_addr[3:1]];

    always_comb begin
        if (dmp_addr > 8'd15) begin
            dmp_din = 8'h00;
        end else begin
            dmp_din = dmp_addr[0] ? dmp_word[15:8] : dmp_word[7:0];
        end
    end

    // controller writeback and post-increment must not collide
    a_no_wr_inc_clash: assert property (@(posedge clk) disable iff (!arst_n)
        cen && we && reg_inc |-> dst != idx_rdreg_sel);

endmodule

//--- idxaddr/cpu_idxaddr.sv
`timescale 1ns/1ns

module cpu_idxaddr import cpu_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     cen,

    input  logic     idx_en,
    input  word_t    op,
    input  word_t    idx_rdreg,
    input  logic     idx_done,

    output reg_sel_t idx_rdreg_sel,
    output logic [1:0] reg_step,
    output logic     reg_inc,
    output logic     idx_ok,
    output addr_t    idx_addr
);

    logic  post_inc;
    logic  inc_op;
    addr_t offset;

    assign post_inc = op[15:12] == op_ldxp || op[15:12] == op_stxp;

    // post-increment forms use the bare index register
    assign offset = post_inc ? '0 : {{18{op[5]}}, op[5:0]};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            idx_ok  <= 1'b0;
            inc_op  <= 1'b0;
            reg_inc <= 1'b0;
        end else if (cen) begin
            if (idx_en) begin
                idx_ok <= 1'b1;
                inc_op <= post_inc;
            end else if (idx_done) begin
                idx_ok <= 1'b0;
            end
            reg_inc <= idx_done && inc_op;
        end
    end

    always_ff @(posedge clk) begin
        if (cen && idx_en) begin
            idx_addr      <= {8'h00, idx_rdreg} + offset;
            idx_rdreg_sel <= op[8:6];
        end
    end

    assign reg_step = inc_op ? 2'd2 : 2'd0;

endmodule

//--- ctrl/cpu_ctrl.sv
`timescale 1ns/1ns

module cpu_ctrl import cpu_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     cen,

    // fetched word from the RAM controller
    input  word_t    op,
    input  logic     op_ok,

    input  logic     idx_ok,
    input  addr_t    idx_addr,
    input  word_t    src_out,
    input  word_t    dst_out,
    input  addr_t    pc,

    output logic     ldram_en,
    output logic     stram_en,
    output logic     byte_st,
    output addr_t    rd_addr,

    output logic     idx_en,
    output logic     idx_done,

    output logic     pc_step,
    output logic     pc_load,
    output addr_t    jump_addr,

    output logic     regs_we,
    output reg_sel_t regs_src,
    output reg_sel_t regs_dst,
    output word_t    wr_data,

    output logic     halted
);

    ctrl_state_e state;
    word_t       ir;
    word_t       wb_data;
    op_t         opc;
    logic        is_load;
    logic        is_store;
    logic        is_idx;
    logic        needs_imm;

    assign opc       = ir[15:12];
    assign is_load   = opc == op_ldx || opc == op_ldxp;
    assign is_store  = opc == op_stx || opc == op_stxp || opc == op_stbx;
    assign is_idx    = is_load || is_store;
    // checked on the word still on the RAM data bus
    assign needs_imm = op[15:12] == op_ldi || op[15:12] == op_jp;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= st_reset;
            ir    <= '0;
        end else if (cen) begin
            case (state)
                st_reset:   state <= st_fetch;
                st_fetch:   state <= st_fetch_wait;
                st_fetch_wait: begin
                    if (op_ok) begin
                        ir    <= op;
                        state <= needs_imm ? st_fetch_imm : st_decode;
                    end
                end
                st_fetch_imm: state <= st_mem;
                st_decode: begin
                    if (opc == op_add || opc == op_sub || is_idx) begin
                        state <= st_exec;
                    end else if (opc == op_halt) begin
                        state <= st_halted;
                    end else begin
                        // nop and unknown opcodes
                        state <= st_fetch;
                    end
                end
                st_exec: begin
                    if (!is_idx) begin
                        state <= st_wb;
                    end else if (idx_ok) begin
                        state <= st_mem;
                    end
                end
                st_mem: begin
                    if (op_ok) begin
                        state <= (opc == op_jp || is_store) ? st_fetch : st_wb;
                    end
                end
                st_wb:      state <= st_fetch;
                st_halted:  state <= st_halted;
                default:    state <= st_fetch;
            endcase
        end
    end

    // ALU result or loaded word, written back in st_wb
    always_ff @(posedge clk) begin
        if (cen) begin
            if (state == st_exec && !is_idx) begin
                wb_data <= (opc == op_sub) ? dst_out - src_out : dst_out + src_out;
            end else if (state == st_mem && op_ok) begin
                wb_data <= op;
            end
        end
    end

    assign ldram_en  = state == st_fetch || state == st_fetch_imm ||
                       (state == st_exec && idx_ok && is_load);
    assign stram_en  = state == st_exec && idx_ok && is_store;
    assign byte_st   = opc == op_stbx;
    assign rd_addr   = (state == st_exec) ? idx_addr : pc;

    assign idx_en    = state == st_decode && is_idx;
    assign idx_done  = (state == st_wb && is_idx) || (state == st_mem && op_ok && is_store);

    // step past the opcode, and past the immediate of ldi
    assign pc_step   = (state == st_fetch_wait && op_ok) ||
                       (state == st_mem && op_ok && opc == op_ldi);
    assign pc_load   = state == st_mem && op_ok && opc == op_jp;
    assign jump_addr = {8'h00, op};

    assign regs_we   = state == st_wb;
    assign regs_src  = ir[8:6];
    assign regs_dst  = ir[11:9];
    assign wr_data   = wb_data;

    assign halted    = state == st_halted;

    // the RAM controller answers only while a request is outstanding
    a_rdy_when_waiting: assert property (@(posedge clk) disable iff (!arst_n)
        cen && op_ok |-> (state == st_fetch_wait || state == st_mem));

endmodule

//--- logic/cpu_ramctl.sv
`timescale 1ns/1ns

module cpu_ramctl import cpu_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       cen,

    input  logic       ldram_en,
    input  logic       stram_en,
    input  logic       byte_st,
    input  addr_t      rd_addr,
    input  addr_t      idx_addr,
    input  word_t      reg_dout,

    output addr_t      ram_addr,
    input  word_t      ram_dout,
    output word_t      ram_din,
    output logic [1:0] ram_we,

    output word_t      dout,
    output logic       ram_rdy
);

    ram_state_e state;
    logic       rd_wait;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= ram_idle;
            rd_wait  <= 1'b0;
            ram_addr <= '0;
            ram_we   <= 2'b00;
            ram_rdy  <= 1'b0;
        end else if (cen) begin
            ram_rdy <= 1'b0;
            case (state)
                ram_idle: begin
                    if (ldram_en) begin
                        ram_addr <= rd_addr;
                        rd_wait  <= 1'b1;
                        state    <= ram_read;
                    end else if (stram_en) begin
                        ram_addr <= idx_addr;
                        // even byte address is the low lane
                        if (byte_st) begin
                            ram_we <= idx_addr[0] ? 2'b10 : 2'b01;
                        end else begin
                            ram_we <= 2'b11;
                        end
                        state <= ram_write;
                    end
                end
                ram_read: begin
                    // RAM data is one enabled cycle behind the address
                    if (rd_wait) begin
                        rd_wait <= 1'b0;
                    end else begin
                        ram_rdy <= 1'b1;
                        state   <= ram_idle;
                    end
                end
                ram_write: begin
                    ram_we  <= 2'b00;
                    ram_rdy <= 1'b1;
                    state   <= ram_idle;
                end
                default: state <= ram_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (cen) begin
            if (state == ram_idle && !ldram_en && stram_en) begin
                ram_din <= byte_st ? {reg_dout[7:0], reg_dout[7:0]} : reg_dout;
            end
            if (state == ram_read && !rd_wait) begin
                dout <= ram_dout;
            end
        end
    end

    a_no_req_busy: assert property (@(posedge clk) disable iff (!arst_n)
        cen && state != ram_idle |-> !(ldram_en || stram_en));

endmodule

//--- logic/cpu_pc.sv
`timescale 1ns/1ns

module cpu_pc import cpu_pkg::*; #(
    parameter addr_t pc_start = 24'h000000
) (
    input  logic  clk,
    input  logic  arst_n,
    input  logic  cen,

    input  logic  pc_step,
    input  logic  pc_load,
    input  addr_t jump_addr,

    output addr_t pc
);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= pc_start;
        end else if (cen) begin
            // jump wins over step
            if (pc_load) begin
                pc <= jump_addr;
            end else if (pc_step) begin
                pc <= pc + 24'd2;
            end
        end
    end

endmodule

//--- logic/cpu_core.sv
`timescale 1ns/1ns

module cpu_core import cpu_pkg::*; #(
    parameter addr_t pc_start = 24'h000000
) (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       cen,

    output addr_t      ram_addr,
    input  word_t      ram_dout,
    output word_t      ram_din,
    output logic [1:0] ram_we,

    // register dump
    input  logic [7:0] dmp_addr,
    output logic [7:0] dmp_din,

    output logic       halted
);

    word_t      src_out;
    word_t      dst_out;
    reg_sel_t   regs_src;
    reg_sel_t   regs_dst;
    logic       regs_we;
    word_t      wr_data;

    // index unit
    reg_sel_t   idx_rdreg_sel;
    logic [1:0] reg_step;
    logic       reg_inc;
    logic       idx_en;
    logic       idx_ok;
    logic       idx_done;
    addr_t      idx_addr;

    // RAM controller
    logic       ldram_en;
    logic       stram_en;
    logic       byte_st;
    addr_t      rd_addr;
    word_t      buf_dout;
    logic       buf_rdy;

    addr_t      pc;
    logic       pc_step;
    logic       pc_load;
    addr_t      jump_addr;

    cpu_regs u_regs (
        .clk            ( clk           ),
        .arst_n         ( arst_n        ),
        .cen            ( cen           ),
        .src            ( regs_src      ),
        .dst            ( regs_dst      ),
        .we             ( regs_we       ),
        .wr_data        ( wr_data       ),
        .idx_rdreg_sel  ( idx_rdreg_sel ),
        .reg_inc        ( reg_inc       ),
        .reg_step       ( reg_step      ),
        .src_out        ( src_out       ),
        .dst_out        ( dst_out       ),
        .dmp_addr       ( dmp_addr      ),
        .dmp_din        ( dmp_din       )
    );

    cpu_idxaddr u_idxaddr (
        .clk            ( clk           ),
        .arst_n         ( arst_n        ),
        .cen            ( cen           ),
        .idx_en         ( idx_en        ),
        .op             ( buf_dout      ),
        .idx_rdreg      ( src_out       ),
        .idx_done       ( idx_done      ),
        .idx_rdreg_sel  ( idx_rdreg_sel ),
        .reg_step       ( reg_step      ),
        .reg_inc        ( reg_inc       ),
        .idx_ok         ( idx_ok        ),
        .idx_addr       ( idx_addr      )
    );

    cpu_ctrl u_ctrl (
        .clk            ( clk           ),
        .arst_n         ( arst_n        ),
        .cen            ( cen           ),
        .op             ( buf_dout      ),
        .op_ok          ( buf_rdy       ),
        .idx_ok         ( idx_ok        ),
        .idx_addr       ( idx_addr      ),
        .src_out        ( src_out       ),
        .dst_out        ( dst_out       ),
        .pc             ( pc            ),
        .ldram_en       ( ldram_en      ),
        .stram_en       ( stram_en      ),
        .byte_st        ( byte_st       ),
        .rd_addr        ( rd_addr       ),
        .idx_en         ( idx_en        ),
        .idx_done       ( idx_done      ),
        .pc_step        ( pc_step       ),
        .pc_load        ( pc_load       ),
        .jump_addr      ( jump_addr     ),
        .regs_we        ( regs_we       ),
        .regs_src       ( regs_src      ),
        .regs_dst       ( regs_dst      ),
        .wr_data        ( wr_data       ),
        .halted         ( halted        )
    );

    // store data is the rd field, read on the dst port
    cpu_ramctl u_ramctl (
        .clk            ( clk           ),
        .arst_n         ( arst_n        ),
        .cen            ( cen           ),
        .ldram_en       ( ldram_en      ),
        .stram_en       ( stram_en      ),
        .byte_st        ( byte_st       ),
        .rd_addr        ( rd_addr       ),
        .idx_addr       ( idx_addr      ),
        .reg_dout       ( dst_out       ),
        .ram_addr       ( ram_addr      ),
        .ram_dout       ( ram_dout      ),
        .ram_din        ( ram_din       ),
        .ram_we         ( ram_we        ),
        .dout           ( buf_dout      ),
        .ram_rdy        ( buf_rdy       )
    );

    cpu_pc #(
        .pc_start       ( pc_start      )
    ) u_pc (
        .clk            ( clk           ),
        .arst_n         ( arst_n        ),
        .cen            ( cen           ),
        .pc_step        ( pc_step       ),
        .pc_load        ( pc_load       ),
        .jump_addr      ( jump_addr     ),
        .pc             ( pc            )
    );

endmodule

//--- tb/tb_clk.sv
`timescale 1ns/1ns

module tb_clk #(
    parameter int period_ns = 100
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(period_ns / 2) clk = ~clk;
        end
    end

endmodule

//--- tb/tb_cpu_core.sv
`timescale 1ns/1ns

module tb_cpu_core import cpu_pkg::*; ();

    localparam int ram_words    = 1024;
    localparam int reset_cycles = 10;
    localparam int start_limit  = 50;
    localparam int run_limit    = 5000;
    localparam int hold_cycles  = 50;

    logic       clk;
    logic       arst_n;
    logic       cen;
    addr_t      ram_addr;
    word_t      ram_dout = '0;
    word_t      ram_din;
    logic [1:0] ram_we;
    logic [7:0] dmp_addr;
    logic [7:0] dmp_din;
    logic       halted;

    // preload image, copied into the RAM while reset is low
    word_t image [ram_words];
    word_t mem   [ram_words];

    int    errors;
    int    checks;
    int    exp_reg_num  [$];
    word_t exp_reg_val  [$];
    addr_t exp_mem_addr [$];
    word_t exp_mem_val  [$];

    tb_clk u_clk (
        .clk ( clk )
    );

    cpu_core #(
        .pc_start ( 24'h000000 )
    ) u_dut (
        .clk      ( clk      ),
        .arst_n   ( arst_n   ),
        .cen      ( cen      ),
        .ram_addr ( ram_addr ),
        .ram_dout ( ram_dout ),
        .ram_din  ( ram_din  ),
        .ram_we   ( ram_we   ),
        .dmp_addr ( dmp_addr ),
        .dmp_din  ( dmp_din  ),
        .halted   ( halted   )
    );

    // word RAM, read data one enabled cycle after the address
    always @(posedge clk) begin
        if (!arst_n) begin
            mem      <= image;
            ram_dout <= '0;
        end else if (cen) begin
            ram_dout <= mem[ram_addr[10:1]];
            if (ram_we[0]) begin
                mem[ram_addr[10:1]][7:0] <= ram_din[7:0];
            end
            if (ram_we[1]) begin
                mem[ram_addr[10:1]][15:8] <= ram_din[15:8];
            end
        end
    end

    // enable high about three cycles in four
    initial begin : cen_drive
        int seed_val;
        seed_val = $urandom(8);
        cen = 1'b0;
        forever begin
            @(posedge clk);
            if (arst_n) begin
                cen <= ($urandom_range(3, 0) != 0);
            end else begin
                cen <= 1'b0;
            end
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            $display("FAIL %s expected 0x%0h actual 0x%0h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic load_stim();
        int          fd;
        int          code;
        int          ch;
        logic [7:0]  kind;
        logic [31:0] addr;
        logic [31:0] value;
        for (int i = 0; i < ram_words; i++) begin
            image[i] = 16'((i * 37) ^ 32'hc35a);
        end
        fd = $fopen("tb/cpu_stim.txt", "r");
        if (fd == 0) begin
            $display("cannot open the stim file tb/cpu_stim.txt");
            errors++;
            return;
        end
        while ($fscanf(fd, " %c", kind) == 1) begin
            if (kind == "#") begin
                // skip to end of line
                ch = $fgetc(fd);
                while (ch != 10 && ch != -1) begin
                    ch = $fgetc(fd);
                end
            end else begin
                code = $fscanf(fd, "%h %h", addr, value);
                if (code != 2) begin
                    $display("stim file line of kind %c is missing its values", kind);
                    errors++;
                end else begin
                    case (kind)
                        "P": image[addr[10:1]] = value[15:0];
                        "R": begin
                            exp_reg_num.push_back(int'(addr));
                            exp_reg_val.push_back(value[15:0]);
                        end
                        "M": begin
                            exp_mem_addr.push_back(addr[23:0]);
                            exp_mem_val.push_back(value[15:0]);
                        end
                        default: begin
                            $display("stim file has a line of unknown kind %c", kind);
                            errors++;
                        end
                    endcase
                end
            end
        end
        $fclose(fd);
    endtask

    // low byte then high byte through the dump port
    task automatic read_reg(input int num, output word_t value);
        @(posedge clk);
        dmp_addr <= 8'(num * 2);
        @(negedge clk);
        value[7:0] = dmp_din;
        @(posedge clk);
        dmp_addr <= 8'(num * 2 + 1);
        @(negedge clk);
        value[15:8] = dmp_din;
    endtask

    initial begin : main
        int    cycles;
        word_t value;
        errors   = 0;
        checks   = 0;
        arst_n   = 1'b0;
        dmp_addr = 8'h00;
        load_stim();
        if (exp_reg_num.size() == 0 || exp_mem_addr.size() == 0) begin
            $display("stim file holds no expected register or memory values");
            errors++;
        end

        repeat (reset_cycles) begin
            @(negedge clk);
            check_value("reset ram_we", 0, 32'(ram_we));
            check_value("reset halted", 0, 32'(halted));
        end
        @(posedge clk);
        arst_n <= 1'b1;

        // first enabled edge after reset
        @(negedge clk);
        cycles = 0;
        while (!cen && cycles < start_limit) begin
            @(negedge clk);
            cycles++;
        end
        if (!cen) begin
            $display("timeout: clock enable never went high after reset");
            errors++;
        end
        @(negedge clk);
        check_value("first cycle ram_we", 0, 32'(ram_we));
        check_value("first cycle halted", 0, 32'(halted));

        cycles = 0;
        while (!halted && cycles < run_limit) begin
            @(negedge clk);
            cycles++;
        end
        if (!halted) begin
            $display("timeout: core did not halt within %0d cycles", run_limit);
            errors++;
        end else begin
            // halt is sticky and the bus stays quiet
            repeat (hold_cycles) begin
                @(negedge clk);
                check_value("halt hold halted", 1, 32'(halted));
                check_value("halt hold ram_we", 0, 32'(ram_we));
            end
            for (int i = 0; i < exp_reg_num.size(); i++) begin
                read_reg(exp_reg_num[i], value);
                check_value($sformatf("r%0d", exp_reg_num[i]), 32'(exp_reg_val[i]),
                            32'(value));
            end
            @(posedge clk);
            dmp_addr <= 8'h10;
            @(negedge clk);
            check_value("dump above 15", 0, 32'(dmp_din));
            for (int i = 0; i < exp_mem_addr.size(); i++) begin
                check_value($sformatf("mem[0x%0h]", exp_mem_addr[i]),
                            32'(exp_mem_val[i]), 32'(mem[exp_mem_addr[i][10:1]]));
            end
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- tb/cpu_stim.txt
# P addr word = RAM preload, R reg value = expected register, M addr word = expected RAM
# all values hex, addresses are byte addresses
P 0000 1200
P 0002 0100
P 0004 1400
P 0006 fff0
P 0008 1600
P 000a 0025
P 000c 24c0
P 000e 1800
P 0010 1000
P 0012 38c0
P 0014 4a44
P 0016 4c7e
P 0018 5446
P 001a 587c
P 001c 8450
P 001e 8853
P 0020 1000
P 0022 0120
P 0024 6603
P 0026 6800
P 0028 7a05
P 002a 7c00
P 002c 9000
P 002e 0034
P 0030 1e00
P 0032 dead
P 0034 0000
P 0036 f000
# data words
P 00fc dddd
P 00fe 1234
P 0104 beef
P 0106 cccc
P 0110 1122
P 0112 3344
P 0120 a5a5
P 0122 5a01
P 0124 7777
P 0126 8888
# final registers
R 0 0128
R 1 0100
R 2 0015
R 3 a5a5
R 4 5a01
R 5 beef
R 6 1234
R 7 0000
# final memory
M 00fc 0fdb
M 0106 0015
M 0110 1115
M 0112 db44
M 0124 beef
M 0126 1234

//--- cpu_core.f
common/cpu_pkg.sv
regs/cpu_regs.sv
idxaddr/cpu_idxaddr.sv
ctrl/cpu_ctrl.sv
logic/cpu_ramctl.sv
logic/cpu_pc.sv
logic/cpu_core.sv
tb/tb_clk.sv
tb/tb_cpu_core.sv

//--- Makefile
TOP := tb_cpu_core

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ns \
		--top-module $(TOP) -f cpu_core.f

run: compile
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	@if grep -q "Testbench failed" sim.log; then \
		echo "simulation reported a failure"; exit 1; \
	fi
	@grep -q "Testbench passed" sim.log || (echo "no result found in sim.log"; exit 1)

clean:
	rm -rf obj_dir sim.log
